/* vec_unit_settings.svh */
`ifndef VEC_UNIT_SETTINGS_SVH
`define VEC_UNIT_SETTINGS_SVH

// Width of one vector register in bits
`define VEC_VLEN    64

// Bytes per vector register, one enable bit each
`define VEC_VLENB   8

// Architectural vector registers, v0 doubles as mask
`define VEC_NREGS   32

// AXI4-Lite byte address width, covers 0x00 to 0x14
`define VEC_ADDR_W  5

// Host data bus width
`define VEC_AXI_DW  32

`endif

/* vec_unit_pkg.sv */
`default_nettype none
`include "vec_unit_settings.svh"

package vec_unit_pkg;

    typedef enum logic [2:0] {
        VOP_ADD  = 3'd0,
        VOP_SUB  = 3'd1,
        VOP_AND  = 3'd2,
        VOP_OR   = 3'd3,
        VOP_XOR  = 3'd4,
        VOP_MINU = 3'd5,
        VOP_MAXU = 3'd6
    } vec_op_e;

    typedef enum logic [1:0] {
        SEW_E8   = 2'd0,
        SEW_E16  = 2'd1,
        SEW_E32  = 2'd2,
        SEW_RSVD = 2'd3  // Runs as e32
    } vec_sew_e;

    typedef enum logic [1:0] {
        KIND_ARITH    = 2'd0,
        KIND_MOVE_IN  = 2'd1,
        KIND_MOVE_OUT = 2'd2,
        KIND_NOP      = 2'd3
    } vec_kind_e;

    // Instruction word, kind sits at [31:30] in both views
    typedef union packed {
        struct packed {
            vec_kind_e  kind;
            vec_op_e    op;
            vec_sew_e   sew;
            logic       vm;     // 1 means unmasked
            logic [4:0] vs2;
            logic [4:0] vs1;
            logic [4:0] vd;
            logic [8:0] pad;
        } arith;
        struct packed {
            vec_kind_e                kind;
            logic [4:0]               vd;
            logic [4:0]               vs1;    // Move-out source
            logic [`VEC_VLENB-1:0]    be;     // Move-in byte enables
            logic [11:0]              pad;
        } move;
    } vec_insn_u;

    typedef struct packed {
        logic [4:0]             vd;
        logic [`VEC_VLENB-1:0]  be;
        logic [`VEC_VLEN-1:0]   data;
    } vreg_wr_t;

    typedef struct packed {
        logic [`VEC_VLEN-1:0]   data;
        logic [`VEC_VLENB-1:0]  be;     // Active element bytes
    } alu_out_t;

    // AXI4-Lite channel payloads, ready travels separately
    typedef struct packed {
        logic [`VEC_ADDR_W-1:0] addr;
        logic                   valid;
    } axil_aw_t;

    typedef struct packed {
        logic [`VEC_AXI_DW-1:0]   data;
        logic [`VEC_AXI_DW/8-1:0] strb;
        logic                     valid;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        logic [`VEC_ADDR_W-1:0] addr;
        logic                   valid;
    } axil_ar_t;

    typedef struct packed {
        logic [`VEC_AXI_DW-1:0] data;
        logic [1:0]             resp;
        logic                   valid;
    } axil_r_t;

    localparam logic [1:0] AXI_OKAY   = 2'b00;
    localparam logic [1:0] AXI_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* vector_regbank.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vec_unit_settings.svh"

module vector_regbank (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [4:0]              vs1_addr,
    input  logic [4:0]              vs2_addr,
    input  vec_unit_pkg::vreg_wr_t  wr,
    output logic [`VEC_VLEN-1:0]    v0_mask,
    output logic [`VEC_VLEN-1:0]    vs1_data,
    output logic [`VEC_VLEN-1:0]    vs2_data
);

    logic [`VEC_VLEN-1:0] v0_q;                          // Mask register, held apart
    logic [`VEC_VLEN-1:0] regfile [1:`VEC_NREGS-1];      // v1 .. v31

    // Replace only the enabled bytes
    function automatic logic [`VEC_VLEN-1:0] byte_merge(
        input logic [`VEC_VLEN-1:0]  old_val,
        input logic [`VEC_VLEN-1:0]  new_val,
        input logic [`VEC_VLENB-1:0] be
    );
        logic [`VEC_VLEN-1:0] merged;
        merged = old_val;
        for (int i = 0; i < `VEC_VLENB; i++) begin
            if (be[i]) begin
                merged[8*i+:8] = new_val[8*i+:8];
            end
        end
        return merged;
    endfunction

    // v0 write
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            v0_q <= '0;
        end else if (wr.vd == 5'd0 && |wr.be) begin
            v0_q <= byte_merge(v0_q, wr.data, wr.be);
        end
    end

    // Remaining registers, one write decoder each
    for (genvar j = 1; j < `VEC_NREGS; j++) begin : gen_vreg
        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                regfile[j] <= '0;
            end else if (wr.vd == 5'(j) && |wr.be) begin
                regfile[j] <= byte_merge(regfile[j], wr.data, wr.be);
            end
        end
    end

    assign v0_mask  = v0_q;                                                // Always visible
    assign vs1_data = (vs1_addr == 5'd0) ? v0_q : regfile[vs1_addr];    // Zero latency
    assign vs2_data = (vs2_addr == 5'd0) ? v0_q : regfile[vs2_addr];

endmodule

`default_nettype wire

/* vec_lane_alu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vec_unit_settings.svh"

module vec_lane_alu (
    input  logic [`VEC_VLEN-1:0]     vs1_data,
    input  logic [`VEC_VLEN-1:0]     vs2_data,
    input  logic [`VEC_VLEN-1:0]     v0_mask,
    input  vec_unit_pkg::vec_op_e    op,
    input  vec_unit_pkg::vec_sew_e   sew,
    input  logic                     vm,
    output vec_unit_pkg::alu_out_t   res
);

    import vec_unit_pkg::*;

    logic [2:0]              emask;      // Byte offset bits inside an element
    logic [1:0]              eshift;     // log2 of bytes per element
    logic [`VEC_VLEN-1:0]    sum;
    logic [`VEC_VLEN-1:0]    diff;
    logic [`VEC_VLENB-1:0]   sub_cout;   // Carry out of vs2 - vs1 per byte

    always_comb begin
        case (sew)
            SEW_E8: begin
                emask  = 3'b000;
                eshift = 2'd0;
            end
            SEW_E16: begin
                emask  = 3'b001;
                eshift = 2'd1;
            end
            default: begin       // e32, reserved code too
                emask  = 3'b011;
                eshift = 2'd2;
            end
        endcase
    end

    // Byte-sliced adder and subtractor
    // Chains restart at each element's first byte
    always_comb begin
        logic [8:0] s_add;
        logic [8:0] s_sub;
        logic       c_add;
        logic       c_sub;
        c_add = 1'b0;
        c_sub = 1'b1;
        for (int i = 0; i < `VEC_VLENB; i++) begin
            if ((3'(i) & emask) == 3'b000) begin
                c_add = 1'b0;
                c_sub = 1'b1;    // Two's complement +1
            end
            s_add = {1'b0, vs2_data[8*i+:8]} + {1'b0, vs1_data[8*i+:8]} + {8'd0, c_add};
            s_sub = {1'b0, vs2_data[8*i+:8]} + {1'b0, ~vs1_data[8*i+:8]} + {8'd0, c_sub};
            sum[8*i+:8]  = s_add[7:0];
            diff[8*i+:8] = s_sub[7:0];
            sub_cout[i]  = s_sub[8];
            c_add = s_add[8];
            c_sub = s_sub[8];
        end
    end

    // Per-byte result select and mask expansion
    always_comb begin
        logic [2:0] top;
        logic [2:0] elem;
        logic       lt;
        res = '0;
        for (int i = 0; i < `VEC_VLENB; i++) begin
            top  = 3'(i) | emask;       // Last byte of this element
            elem = 3'(i) >> eshift;     // Element index, picks v0 bit
            lt   = !sub_cout[top];      // No carry out means vs2 < vs1
            case (op)
                VOP_ADD:  res.data[8*i+:8] = sum[8*i+:8];
                VOP_SUB:  res.data[8*i+:8] = diff[8*i+:8];
                VOP_AND:  res.data[8*i+:8] = vs2_data[8*i+:8] & vs1_data[8*i+:8];
                VOP_OR:   res.data[8*i+:8] = vs2_data[8*i+:8] | vs1_data[8*i+:8];
                VOP_XOR:  res.data[8*i+:8] = vs2_data[8*i+:8] ^ vs1_data[8*i+:8];
                VOP_MINU: res.data[8*i+:8] = lt ? vs2_data[8*i+:8] : vs1_data[8*i+:8];
                VOP_MAXU: res.data[8*i+:8] = lt ? vs1_data[8*i+:8] : vs2_data[8*i+:8];
                default:  res.data[8*i+:8] = 8'd0;
            endcase
            res.be[i] = vm || v0_mask[elem];   // RVV layout, one mask bit per element
        end
    end

endmodule

`default_nettype wire

/* vec_control.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vec_unit_settings.svh"

module vec_control (
    input  logic                     clk,
    input  logic                     reset_n,
    input  vec_unit_pkg::axil_aw_t   aw,
    output logic                     awready,
    input  vec_unit_pkg::axil_w_t    w,
    output logic                     wready,
    output vec_unit_pkg::axil_b_t    b,
    input  logic                     bready,
    input  vec_unit_pkg::axil_ar_t   ar,
    output logic                     arready,
    output vec_unit_pkg::axil_r_t    r,
    input  logic                     rready,
    output logic [4:0]               vs1_addr,
    output logic [4:0]               vs2_addr,
    input  logic [`VEC_VLEN-1:0]     v0_mask,
    input  logic [`VEC_VLEN-1:0]     vs1_data,
    output vec_unit_pkg::vec_op_e    op,
    output vec_unit_pkg::vec_sew_e   sew,
    output logic                     vm,
    input  vec_unit_pkg::alu_out_t   alu_res,
    output vec_unit_pkg::vreg_wr_t   wr
);

    import vec_unit_pkg::*;

    // Register map
    localparam logic [`VEC_ADDR_W-1:0] ADDR_INSN    = 'h00;
    localparam logic [`VEC_ADDR_W-1:0] ADDR_DATA_LO = 'h04;
    localparam logic [`VEC_ADDR_W-1:0] ADDR_DATA_HI = 'h08;
    localparam logic [`VEC_ADDR_W-1:0] ADDR_RB_LO   = 'h0C;
    localparam logic [`VEC_ADDR_W-1:0] ADDR_RB_HI   = 'h10;
    localparam logic [`VEC_ADDR_W-1:0] ADDR_V0      = 'h14;

    logic                  wr_acc;     // AW and W taken this cycle
    logic                  rd_acc;     // AR taken this cycle
    logic                  exec_q;     // Instruction executing
    vec_insn_u             insn_q;
    vec_kind_e             kind;
    logic [`VEC_VLEN-1:0]  stage_q;    // Staging vector
    logic [`VEC_VLEN-1:0]  rb_q;       // Last move-out
    axil_b_t               b_q;
    axil_r_t               r_q;

    // One transaction at a time, writes win a tie
    assign wr_acc  = aw.valid && w.valid && !b_q.valid && !r_q.valid;
    assign rd_acc  = ar.valid && !wr_acc && !exec_q && !b_q.valid && !r_q.valid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = rd_acc;
    assign b       = b_q;
    assign r       = r_q;

    // Write channel, staging and instruction capture
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            b_q     <= '0;
            exec_q  <= 1'b0;
            insn_q  <= '0;
            stage_q <= '0;
        end else begin
            exec_q <= 1'b0;                      // Single execute cycle
            if (b_q.valid && bready) begin
                b_q.valid <= 1'b0;
            end
            if (wr_acc) begin
                b_q.valid <= 1'b1;               // Rises with execute
                b_q.resp  <= AXI_OKAY;
                case (aw.addr)
                    ADDR_INSN: begin
                        if (&w.strb) begin
                            insn_q <= vec_insn_u'(w.data);
                            exec_q <= 1'b1;
                        end else begin
                            b_q.resp <= AXI_SLVERR;  // Partial word, not issued
                        end
                    end
                    ADDR_DATA_LO: begin
                        for (int k = 0; k < 4; k++) begin
                            if (w.strb[k]) begin
                                stage_q[8*k+:8] <= w.data[8*k+:8];
                            end
                        end
                    end
                    ADDR_DATA_HI: begin
                        for (int k = 0; k < 4; k++) begin
                            if (w.strb[k]) begin
                                stage_q[32+8*k+:8] <= w.data[8*k+:8];
                            end
                        end
                    end
                    default: b_q.resp <= AXI_SLVERR;   // Read-only or unmapped
                endcase
            end
        end
    end

    // Read channel
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_q <= '0;
        end else begin
            if (r_q.valid && rready) begin
                r_q.valid <= 1'b0;
            end
            if (rd_acc) begin
                r_q.valid <= 1'b1;
                r_q.resp  <= AXI_OKAY;
                case (ar.addr)
                    ADDR_DATA_LO: r_q.data <= stage_q[31:0];
                    ADDR_DATA_HI: r_q.data <= stage_q[63:32];
                    ADDR_RB_LO:   r_q.data <= rb_q[31:0];
                    ADDR_RB_HI:   r_q.data <= rb_q[63:32];
                    ADDR_V0:      r_q.data <= v0_mask[31:0];
                    default: begin
                        r_q.data <= '0;
                        r_q.resp <= AXI_SLVERR;        // INSN is write only
                    end
                endcase
            end
        end
    end

    // Move-out lands in the read-back pair
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rb_q <= '0;
        end else if (exec_q && kind == KIND_MOVE_OUT) begin
            rb_q <= vs1_data;
        end
    end

    // Decode, view picked by kind
    assign kind     = insn_q.arith.kind;
    assign vs1_addr = (kind == KIND_ARITH) ? insn_q.arith.vs1 : insn_q.move.vs1;
    assign vs2_addr = insn_q.arith.vs2;
    assign op       = insn_q.arith.op;
    assign sew      = insn_q.arith.sew;
    assign vm       = insn_q.arith.vm;

    // Write port steering, live only in the execute cycle
    always_comb begin
        wr = '0;
        if (exec_q) begin
            case (kind)
                KIND_ARITH: begin
                    wr.vd   = insn_q.arith.vd;
                    wr.be   = alu_res.be;
                    wr.data = alu_res.data;
                end
                KIND_MOVE_IN: begin
                    wr.vd   = insn_q.move.vd;
                    wr.be   = insn_q.move.be;   // Explicit byte mask
                    wr.data = stage_q;
                end
                default: wr = '0;               // Move-out and no-op write nothing
            endcase
        end
    end

endmodule

`default_nettype wire

/* vec_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vec_unit_settings.svh"

module vec_unit_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  vec_unit_pkg::axil_aw_t   aw,
    output logic                     awready,
    input  vec_unit_pkg::axil_w_t    w,
    output logic                     wready,
    output vec_unit_pkg::axil_b_t    b,
    input  logic                     bready,
    input  vec_unit_pkg::axil_ar_t   ar,
    output logic                     arready,
    output vec_unit_pkg::axil_r_t    r,
    input  logic                     rready
);

    import vec_unit_pkg::*;

    logic [4:0]            vs1_addr;
    logic [4:0]            vs2_addr;
    logic [`VEC_VLEN-1:0]  v0_mask;
    logic [`VEC_VLEN-1:0]  vs1_data;
    logic [`VEC_VLEN-1:0]  vs2_data;   // ALU only
    vec_op_e               op;
    vec_sew_e              sew;
    logic                  vm;
    alu_out_t              alu_res;
    vreg_wr_t              wr;         // Single write port into the bank

    vec_control u_control (
        .clk      (clk),      .reset_n  (reset_n),
        .aw       (aw),       .awready  (awready),
        .w        (w),        .wready   (wready),
        .b        (b),        .bready   (bready),
        .ar       (ar),       .arready  (arready),
        .r        (r),        .rready   (rready),
        .vs1_addr (vs1_addr), .vs2_addr (vs2_addr),
        .v0_mask  (v0_mask),  .vs1_data (vs1_data),
        .op       (op),       .sew      (sew),
        .vm       (vm),       .alu_res  (alu_res),
        .wr       (wr)
    );

    vector_regbank u_regbank (
        .clk      (clk),      .reset_n  (reset_n),
        .vs1_addr (vs1_addr), .vs2_addr (vs2_addr),
        .wr       (wr),       .v0_mask  (v0_mask),
        .vs1_data (vs1_data), .vs2_data (vs2_data)
    );

    vec_lane_alu u_alu (
        .vs1_data (vs1_data), .vs2_data (vs2_data),
        .v0_mask  (v0_mask),  .op       (op),
        .sew      (sew),      .vm       (vm),
        .res      (alu_res)
    );

endmodule

`default_nettype wire

/* vec_unit_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module vec_unit_assertions (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    awready,
    input logic                    wready,
    input logic                    arready,
    input vec_unit_pkg::axil_b_t   b,
    input logic                    bready,
    input vec_unit_pkg::axil_r_t   r,
    input logic                    rready,
    input vec_unit_pkg::vreg_wr_t  wr,
    input logic                    exec
);

    int violations = 0;     // Read by the testbench at the end

    // B payload frozen while stalled
    b_hold: assert property (@(posedge clk) disable iff (!reset_n)
        b.valid && !bready |=> b.valid && $stable(b))
        else begin
            $error("write response changed before bready");
            violations++;
        end

    r_hold: assert property (@(posedge clk) disable iff (!reset_n)
        r.valid && !rready |=> r.valid && $stable(r))
        else begin
            $error("read response changed before rready");
            violations++;
        end

    // Quiet bus and write port in reset
    reset_quiet: assert property (@(posedge clk)
        !reset_n |-> !awready && !wready && !arready && !b.valid && !r.valid && wr.be == '0)
        else begin
            $error("outputs active during reset");
            violations++;
        end

    wr_only_exec: assert property (@(posedge clk) disable iff (!reset_n)
        wr.be != '0 |-> exec)      // Bank written in execute cycle only
        else begin
            $error("register write outside an execute cycle");
            violations++;
        end

endmodule

bind vec_control vec_unit_assertions u_assertions (
    .clk     (clk),     .reset_n (reset_n),
    .awready (awready), .wready  (wready),  .arready (arready),
    .b       (b),       .bready  (bready),
    .r       (r),       .rready  (rready),
    .wr      (wr),      .exec    (exec_q)
);

`default_nettype wire

/* vec_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "vec_unit_settings.svh"

module vec_unit_tb;

    import vec_unit_pkg::*;

    localparam int          CLK_PERIOD      = 4;
    localparam int          RESET_CYCLES    = 10;
    localparam int          CYCLES_PER_LINE = 40;     // Watchdog budget per stimulus line
    localparam logic [31:0] SEED            = 32'h3045cf1e;
    localparam string       STIM_FILE       = "vec_unit_stimulus.txt";
    localparam int          CH_HASH         = 35;     // '#'
    localparam int          CH_W            = 87;     // 'W'
    localparam int          CH_R            = 82;     // 'R'

    logic     clk;
    logic     reset_n;
    axil_aw_t aw;
    logic     awready;
    axil_w_t  w;
    logic     wready;
    axil_b_t  b;
    logic     bready;
    axil_ar_t ar;
    logic     arready;
    axil_r_t  r;
    logic     rready;

    int   line_count;       // Sizes the watchdog
    logic timer_armed;

    vec_unit_top UUT (
        .clk     (clk),     .reset_n (reset_n),
        .aw      (aw),      .awready (awready),
        .w       (w),       .wready  (wready),
        .b       (b),       .bready  (bready),
        .ar      (ar),      .arready (arready),
        .r       (r),       .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Wrong value, stop at once
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    // AW and W together, then a random B stall
    task automatic bus_write(
        input  logic [`VEC_ADDR_W-1:0] addr,
        input  logic [31:0]            data,
        input  logic [3:0]             strb,
        output logic [1:0]             resp
    );
        int stall;
        @(negedge clk);
        aw.addr  = addr;
        aw.valid = 1'b1;
        w.data   = data;
        w.strb   = strb;
        w.valid  = 1'b1;
        #(CLK_PERIOD / 4);                 // Readies settle inside the low phase
        while (!awready) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        assert (wready)
            else report_mismatch("wready", 32'd1, {31'd0, wready});
        @(negedge clk);                    // Handshake edge has passed
        assert (b.valid)
            else report_problem("bvalid did not rise one cycle after the write handshake");
        assert (!awready)
            else report_mismatch("awready", 32'd0, {31'd0, awready});
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        stall = int'($urandom % 4);
        repeat (stall) @(negedge clk);
        resp   = b.resp;                   // Sampled after the stall
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(
        input  logic [`VEC_ADDR_W-1:0] addr,
        output logic [31:0]            data,
        output logic [1:0]             resp
    );
        int stall;
        @(negedge clk);
        ar.addr  = addr;
        ar.valid = 1'b1;
        #(CLK_PERIOD / 4);
        while (!arready) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        @(negedge clk);
        assert (r.valid)
            else report_problem("rvalid did not rise one cycle after the read handshake");
        assert (!arready)
            else report_mismatch("arready", 32'd0, {31'd0, arready});
        ar.valid = 1'b0;
        stall = int'($urandom % 4);
        repeat (stall) @(negedge clk);
        data   = r.data;
        resp   = r.resp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // First non-blank character, -1 at end of file
    function automatic int next_char(input int fd);
        int c;
        c = $fgetc(fd);
        while (c == 32 || c == 9 || c == 10 || c == 13) begin
            c = $fgetc(fd);
        end
        return c;
    endfunction

    function automatic void skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endfunction

    function automatic int count_lines(input int fd);
        int n;
        int c;
        n = 0;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == 10) n++;
            c = $fgetc(fd);
        end
        return n;
    endfunction

    initial begin
        int          fd;
        int          c;
        int          n;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_strb;
        logic [31:0] f_resp;
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        void'($urandom(SEED));
        line_count  = 0;
        timer_armed = 1'b0;
        reset_n     = 1'b0;
        aw          = '0;
        w           = '0;
        ar          = '0;
        bready      = 1'b0;
        rready      = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) report_problem("cannot open the stimulus file");
        line_count = count_lines(fd);
        $fclose(fd);
        timer_armed = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        c  = next_char(fd);
        while (c != -1) begin
            if (c == CH_HASH) begin
                skip_line(fd);
            end else if (c == CH_W) begin
                n = $fscanf(fd, " %h %h %h %h", f_addr, f_data, f_strb, f_resp);
                if (n != 4) report_problem("malformed write line in the stimulus file");
                bus_write(f_addr[`VEC_ADDR_W-1:0], f_data, f_strb[3:0], got_resp);
                assert (got_resp == f_resp[1:0])
                    else report_mismatch("b.resp", {30'd0, f_resp[1:0]}, {30'd0, got_resp});
            end else if (c == CH_R) begin
                n = $fscanf(fd, " %h %h %h", f_addr, f_data, f_resp);
                if (n != 3) report_problem("malformed read line in the stimulus file");
                bus_read(f_addr[`VEC_ADDR_W-1:0], got_data, got_resp);
                assert (got_data == f_data)
                    else report_mismatch("r.data", f_data, got_data);
                assert (got_resp == f_resp[1:0])
                    else report_mismatch("r.resp", {30'd0, f_resp[1:0]}, {30'd0, got_resp});
            end else begin
                report_problem("unknown command in the stimulus file");
            end
            c = next_char(fd);
        end
        $fclose(fd);
        repeat (4) @(negedge clk);   // Let bound assertions see the tail
        if (UUT.u_control.u_assertions.violations == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (timer_armed);
        #((line_count * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
        report_problem("watchdog expired before the stimulus file was finished");
    end

endmodule

`default_nettype wire

/* vec_unit_stimulus.txt */
# W addr wdata strobe bresp
# R addr rdata rresp   (hex fields, data and responses are the expected DUT values)
# Reset state and unmapped or read-only accesses
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 2
W 18 12345678 f 2
W 0C 12345678 f 2
# Stage a vector, move it into v1 and back out
W 04 44332211 f 0
W 08 88776655 f 0
W 00 420FF000 f 0
W 00 80100000 f 0
R 0C 44332211 0
R 10 88776655 0
# Partial strobes on staging, then byte mask 3C into v1
W 04 AABBCCDD 5 0
W 08 EEFF0011 a 0
R 04 44BB22DD 0
R 08 EE770055 0
W 00 4203C000 f 0
W 00 80100000 f 0
R 0C 44BB2211 0
R 10 88770055 0
# v2 holds the second operand, vd is v4, vs1 is v1
W 04 BC45DEEF f 0
W 08 7889FFAB f 0
W 00 440FF000 f 0
# add e8, e16, e32
W 00 01104800 f 0
W 00 80400000 f 0
R 0C 00000000 0
R 10 0000FF00 0
W 00 03104800 f 0
W 00 80400000 f 0
R 0C 01000100 0
R 10 01000000 0
W 00 05104800 f 0
W 00 80400000 f 0
R 0C 01010100 0
R 10 01010000 0
# sub e32, minu e8, maxu e16
W 00 0D104800 f 0
W 00 80400000 f 0
R 0C 778ABCDE 0
R 10 F012FF56 0
W 00 29104800 f 0
W 00 80400000 f 0
R 0C 44452211 0
R 10 78770055 0
W 00 33104800 f 0
W 00 80400000 f 0
R 0C BC45DEEF 0
R 10 8877FFAB 0
# v0 mask A5, masked add e8 and sub e16
W 04 000000A5 f 0
W 08 00000000 f 0
W 00 400FF000 f 0
R 14 000000A5 0
W 00 00104800 f 0
W 00 80400000 f 0
R 0C BC00DE00 0
R 10 0077FFAB 0
W 00 0A104800 f 0
W 00 80400000 f 0
R 0C BC00BCDE 0
R 10 0077FF56 0
# INSN with partial strobes is refused
W 00 80100000 7 2
R 0C BC00BCDE 0
R 10 0077FF56 0

/* vec_unit.f */
+incdir+.
vec_unit_pkg.sv
vector_regbank.sv
vec_lane_alu.sv
vec_control.sv
vec_unit_top.sv
vec_unit_assertions.sv
vec_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module vec_unit_tb \
    -f vec_unit.f

status=0
sim_out=$(./obj_dir/Vvec_unit_tb 2>&1) || status=$?
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "Simulation did not pass (exit status $status)"
exit 1
